/* hdl/riscv_pkg.sv */
// RISC-V ISA constants

`default_nettype none

package riscv_pkg;

    // width of a fetch address and of the boot vector
    localparam int unsigned PC_BITS = 32;

    // one uncompressed instruction, PC step between sequential fetches
    localparam logic [PC_BITS-1:0] INSN_BYTES = 32'd4;

    // default reset vector
    // start of main memory on most RISC-V boards
    localparam logic [PC_BITS-1:0] DEFAULT_BOOT_PC = 32'h8000_0000;

endpackage : riscv_pkg

`default_nettype wire

/* hdl/drac_pkg.sv */
// DRAC pipeline control encodings

`default_nettype none

package drac_pkg;

    // IF, ID, RR, EXE, WB
    localparam int unsigned NUM_STAGES = 5;

    // stage indices into the flush and stall vectors
    localparam int unsigned STAGE_IF = 0;
    localparam int unsigned STAGE_WB = NUM_STAGES - 1;

    // what the PC register does on the next edge
    typedef enum logic [1:0] {
        // keep current fetch address
        NEXT_PC_SEL_PC   = 2'b00,
        // sequential fetch
        NEXT_PC_SEL_PC_4 = 2'b01,
        // redirect, address picked by jump_addr_sel_t
        NEXT_PC_SEL_JUMP = 2'b10
    } next_pc_sel_t;

    // source of the redirect address
    typedef enum logic [1:0] {
        // jal target from decode
        SEL_JUMP_DECODE = 2'b00,
        // resolved branch target at commit
        SEL_JUMP_COMMIT = 2'b01,
        // trap vector or return address from the CSR file
        SEL_JUMP_CSR    = 2'b10
    } jump_addr_sel_t;

endpackage : drac_pkg

`default_nettype wire

/* hdl/pipeline_ctrl_if.sv */
// Pipeline control bundle

`timescale 1ns/1ps
`default_nettype none

interface pipeline_ctrl_if;
    import drac_pkg::*;

    // per stage, bit 0 is IF and the top bit is WB
    logic [NUM_STAGES-1:0] flush;
    logic [NUM_STAGES-1:0] stall;

    // redirect address source for fetch
    jump_addr_sel_t        sel_addr_if;
    // hold, advance or redirect
    next_pc_sel_t          next_pc;

    // control unit owns every signal
    modport cu (
        output flush,
        output stall,
        output sel_addr_if,
        output next_pc
    );

    // PC generator only needs the fetch decision
    modport pc (
        input next_pc,
        input sel_addr_if
    );

    // valid chain follows flushes and stalls
    modport chain (
        input flush,
        input stall
    );

endinterface : pipeline_ctrl_if

`default_nettype wire

/* hdl/control_unit.sv */
// Pipeline control unit

`timescale 1ns/1ps
`default_nettype none

module control_unit (
    input  logic              clk_i,
    input  logic              rst_i,

    // fetch
    input  logic              valid_fetch_i,

    // decode
    input  logic              id_valid_jal_i,
    input  logic              id_stall_csr_i,

    // register read
    input  logic              rr_stall_csr_i,

    // execute
    input  logic              exe_stall_csr_i,
    input  logic              exe_stall_i,

    // writeback / commit
    input  logic              wb_valid_i,
    input  logic              wb_xcpt_i,
    input  logic              wb_branch_taken_i,
    input  logic              wb_change_pc_ena_i,
    input  logic              wb_ecall_taken_i,
    input  logic              wb_write_enable_i,

    // CSR file
    input  logic              csr_eret_i,
    input  logic              csr_exception_i,
    input  logic              csr_stall_i,

    output logic              rf_write_enable_o,
    pipeline_ctrl_if.cu       ctrl
);
    import drac_pkg::*;

    // trap class events, all go to the CSR vector
    logic                  csr_event;
    // taken branch reaching commit
    logic                  branch_commit;
    // some stage waits on a CSR access
    logic                  csr_stall_any;
    // global front end stall
    logic                  pipe_stall;
    // any redirect of the fetch PC
    logic                  jump_enable;
    // local copy so the IF stall can feed next_pc
    logic [NUM_STAGES-1:0] stall_int;

    always_comb begin
        csr_event     = (wb_valid_i && wb_xcpt_i) ||
                        csr_eret_i ||
                        csr_exception_i ||
                        (wb_valid_i && wb_ecall_taken_i);
        branch_commit = wb_valid_i && wb_branch_taken_i;
        csr_stall_any = id_stall_csr_i || rr_stall_csr_i || exe_stall_csr_i;
        pipe_stall    = csr_stall_i || exe_stall_i;
    end

    // redirect sources
    // a taken branch only moves the PC with change_pc_ena set
    always_comb begin
        jump_enable = csr_event ||
                      (branch_commit && wb_change_pc_ena_i) ||
                      id_valid_jal_i;
    end

    // regfile write at commit
    // dropped when the instruction traps
    always_comb begin
        rf_write_enable_o = wb_valid_i &&
                            !wb_xcpt_i &&
                            !csr_exception_i &&
                            wb_write_enable_i;
    end

    // stalls
    // WB always drains
    always_comb begin
        stall_int = '0;
        if (pipe_stall) begin
            for (int i = STAGE_IF; i < STAGE_WB; i++) begin
                stall_int[i] = 1'b1;
            end
        end
        ctrl.stall = stall_int;
    end

    // next pc decision
    always_comb begin
        if (jump_enable) begin
            ctrl.next_pc = NEXT_PC_SEL_JUMP;
        end else if (!valid_fetch_i || stall_int[STAGE_IF] || csr_stall_any) begin
            // nothing fetched or front end blocked
            ctrl.next_pc = NEXT_PC_SEL_PC;
        end else begin
            ctrl.next_pc = NEXT_PC_SEL_PC_4;
        end
    end

    // redirect address source, traps win over branches
    always_comb begin
        if (csr_event) begin
            ctrl.sel_addr_if = SEL_JUMP_CSR;
        end else if (branch_commit) begin
            ctrl.sel_addr_if = SEL_JUMP_COMMIT;
        end else begin
            ctrl.sel_addr_if = SEL_JUMP_DECODE;
        end
    end

    // flushes
    always_comb begin
        ctrl.flush = '0;
        if (csr_event || branch_commit) begin
            // kill everything younger than commit
            for (int i = STAGE_IF; i < STAGE_WB; i++) begin
                ctrl.flush[i] = 1'b1;
            end
        end else if (csr_stall_any || id_valid_jal_i) begin
            // only the instruction just fetched is wrong
            ctrl.flush[STAGE_IF] = 1'b1;
        end
    end

endmodule : control_unit

`default_nettype wire

/* hdl/pc_gen.sv */
// Fetch program counter

`timescale 1ns/1ps
`default_nettype none

module pc_gen #(
    parameter int unsigned           ADDR_WIDTH = 32,
    parameter logic [ADDR_WIDTH-1:0] RESET_PC   = ADDR_WIDTH'(riscv_pkg::DEFAULT_BOOT_PC)
) (
    input  logic                  clk_i,
    input  logic                  rst_i,

    // redirect targets
    input  logic [ADDR_WIDTH-1:0] id_jump_addr_i,
    input  logic [ADDR_WIDTH-1:0] wb_branch_target_i,
    input  logic [ADDR_WIDTH-1:0] csr_evec_i,

    pipeline_ctrl_if.pc           ctrl,

    output logic [ADDR_WIDTH-1:0] pc_o
);
    import riscv_pkg::*;
    import drac_pkg::*;

    logic [ADDR_WIDTH-1:0] pc_q;
    logic [ADDR_WIDTH-1:0] pc_d;
    // selected redirect address
    logic [ADDR_WIDTH-1:0] jump_addr;

    // redirect mux
    always_comb begin
        case (ctrl.sel_addr_if)
            SEL_JUMP_COMMIT: jump_addr = wb_branch_target_i;
            SEL_JUMP_CSR:    jump_addr = csr_evec_i;
            default:         jump_addr = id_jump_addr_i;
        endcase
    end

    // next value
    always_comb begin
        case (ctrl.next_pc)
            NEXT_PC_SEL_PC_4: pc_d = pc_q + ADDR_WIDTH'(INSN_BYTES);
            NEXT_PC_SEL_JUMP: pc_d = jump_addr;
            // hold, also for the unused code
            default:          pc_d = pc_q;
        endcase
    end

    // one cycle from decision to new pc
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

    assign pc_o = pc_q;

endmodule : pc_gen

`default_nettype wire

/* hdl/stage_valid_chain.sv */
// Per-stage valid bits

`timescale 1ns/1ps
`default_nettype none

module stage_valid_chain (
    input  logic                            clk_i,
    input  logic                            rst_i,

    // fetch produced an instruction this cycle
    input  logic                            valid_fetch_i,

    pipeline_ctrl_if.chain                  ctrl,

    output logic [drac_pkg::NUM_STAGES-1:0] stage_valid_o
);
    import drac_pkg::*;

    // bit 0 is IF, top bit is WB
    logic [NUM_STAGES-1:0] valid_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
        end else begin
            // IF loads straight from the fetch report
            if (!ctrl.stall[STAGE_IF]) begin
                valid_q[STAGE_IF] <= valid_fetch_i;
            end

            // older stages take the younger bit
            // a flushed stage hands on a bubble
            for (int i = STAGE_IF + 1; i < NUM_STAGES; i++) begin
                if (!ctrl.stall[i]) begin
                    valid_q[i] <= valid_q[i-1] && !ctrl.flush[i-1];
                end
            end
        end
    end

    assign stage_valid_o = valid_q;

endmodule : stage_valid_chain

`default_nettype wire

/* hdl/drac_ctrl_top.sv */
// DRAC pipeline control top

`timescale 1ns/1ps
`default_nettype none

module drac_ctrl_top #(
    parameter int unsigned           ADDR_WIDTH = 32,
    parameter logic [ADDR_WIDTH-1:0] RESET_PC   = ADDR_WIDTH'(riscv_pkg::DEFAULT_BOOT_PC)
) (
    input  logic                            clk_i,
    input  logic                            rst_i,

    // stage reports
    input  logic                            valid_fetch_i,
    input  logic                            id_valid_jal_i,
    input  logic                            id_stall_csr_i,
    input  logic                            rr_stall_csr_i,
    input  logic                            exe_stall_csr_i,
    input  logic                            exe_stall_i,
    input  logic                            wb_valid_i,
    input  logic                            wb_xcpt_i,
    input  logic                            wb_branch_taken_i,
    input  logic                            wb_change_pc_ena_i,
    input  logic                            wb_ecall_taken_i,
    input  logic                            wb_write_enable_i,
    input  logic                            csr_eret_i,
    input  logic                            csr_exception_i,
    input  logic                            csr_stall_i,

    // redirect targets from the datapath
    input  logic [ADDR_WIDTH-1:0]           id_jump_addr_i,
    input  logic [ADDR_WIDTH-1:0]           wb_branch_target_i,
    input  logic [ADDR_WIDTH-1:0]           csr_evec_i,

    output logic [ADDR_WIDTH-1:0]           pc_o,
    output logic                            rf_write_enable_o,
    output logic [drac_pkg::NUM_STAGES-1:0] stage_valid_o,
    output logic [drac_pkg::NUM_STAGES-1:0] flush_o,
    output logic [drac_pkg::NUM_STAGES-1:0] stall_o
);

    pipeline_ctrl_if ctrl_if ();

    // decisions, same cycle
    control_unit u_control_unit (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .valid_fetch_i      (valid_fetch_i),
        .id_valid_jal_i     (id_valid_jal_i),
        .id_stall_csr_i     (id_stall_csr_i),
        .rr_stall_csr_i     (rr_stall_csr_i),
        .exe_stall_csr_i    (exe_stall_csr_i),
        .exe_stall_i        (exe_stall_i),
        .wb_valid_i         (wb_valid_i),
        .wb_xcpt_i          (wb_xcpt_i),
        .wb_branch_taken_i  (wb_branch_taken_i),
        .wb_change_pc_ena_i (wb_change_pc_ena_i),
        .wb_ecall_taken_i   (wb_ecall_taken_i),
        .wb_write_enable_i  (wb_write_enable_i),
        .csr_eret_i         (csr_eret_i),
        .csr_exception_i    (csr_exception_i),
        .csr_stall_i        (csr_stall_i),
        .rf_write_enable_o  (rf_write_enable_o),
        .ctrl               (ctrl_if.cu)
    );

    // fetch address register
    pc_gen #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .RESET_PC   (RESET_PC)
    ) u_pc_gen (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .id_jump_addr_i     (id_jump_addr_i),
        .wb_branch_target_i (wb_branch_target_i),
        .csr_evec_i         (csr_evec_i),
        .ctrl               (ctrl_if.pc),
        .pc_o               (pc_o)
    );

    // in-flight occupancy
    stage_valid_chain u_stage_valid_chain (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .valid_fetch_i (valid_fetch_i),
        .ctrl          (ctrl_if.chain),
        .stage_valid_o (stage_valid_o)
    );

    // control levels out to the datapath
    assign flush_o = ctrl_if.flush;
    assign stall_o = ctrl_if.stall;

endmodule : drac_ctrl_top

`default_nettype wire

/* tests/tb_drac_ctrl.sv */
// Pipeline control testbench

`timescale 1ns/1ps
`default_nettype none

module tb_drac_ctrl;
    import riscv_pkg::*;
    import drac_pkg::*;

    localparam int unsigned ADDR_WIDTH     = 32;
    // not the package default, so the parameter path is exercised
    localparam logic [31:0] RESET_PC       = 32'h0000_1000;
    localparam int unsigned RESET_CYCLES   = 16;
    localparam int unsigned NUM_CYCLES     = 2000;
    // random cycles plus reset and margin
    localparam int unsigned TIMEOUT_CYCLES = NUM_CYCLES + RESET_CYCLES + 84;

    // IF through EXE
    localparam logic [NUM_STAGES-1:0] FRONT_STAGES = {1'b0, {(NUM_STAGES-1){1'b1}}};
    localparam logic [NUM_STAGES-1:0] ONLY_IF      = {{(NUM_STAGES-1){1'b0}}, 1'b1};

    logic                  clk_i;
    logic                  rst_i;
    logic                  valid_fetch_i;
    logic                  id_valid_jal_i;
    logic                  id_stall_csr_i;
    logic                  rr_stall_csr_i;
    logic                  exe_stall_csr_i;
    logic                  exe_stall_i;
    logic                  wb_valid_i;
    logic                  wb_xcpt_i;
    logic                  wb_branch_taken_i;
    logic                  wb_change_pc_ena_i;
    logic                  wb_ecall_taken_i;
    logic                  wb_write_enable_i;
    logic                  csr_eret_i;
    logic                  csr_exception_i;
    logic                  csr_stall_i;
    logic [31:0]           id_jump_addr_i;
    logic [31:0]           wb_branch_target_i;
    logic [31:0]           csr_evec_i;
    logic [31:0]           pc_o;
    logic                  rf_write_enable_o;
    logic [NUM_STAGES-1:0] stage_valid_o;
    logic [NUM_STAGES-1:0] flush_o;
    logic [NUM_STAGES-1:0] stall_o;

    // model state, as seen after each rising edge
    logic [31:0]           model_pc;
    logic [NUM_STAGES-1:0] model_valid;
    logic [31:0]           rand_state;
    int unsigned           error_cnt;
    int unsigned           check_cnt;
    int unsigned           cycle_cnt = 0;

    drac_ctrl_top #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .RESET_PC   (RESET_PC)
    ) u_drac_ctrl_top (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .valid_fetch_i      (valid_fetch_i),
        .id_valid_jal_i     (id_valid_jal_i),
        .id_stall_csr_i     (id_stall_csr_i),
        .rr_stall_csr_i     (rr_stall_csr_i),
        .exe_stall_csr_i    (exe_stall_csr_i),
        .exe_stall_i        (exe_stall_i),
        .wb_valid_i         (wb_valid_i),
        .wb_xcpt_i          (wb_xcpt_i),
        .wb_branch_taken_i  (wb_branch_taken_i),
        .wb_change_pc_ena_i (wb_change_pc_ena_i),
        .wb_ecall_taken_i   (wb_ecall_taken_i),
        .wb_write_enable_i  (wb_write_enable_i),
        .csr_eret_i         (csr_eret_i),
        .csr_exception_i    (csr_exception_i),
        .csr_stall_i        (csr_stall_i),
        .id_jump_addr_i     (id_jump_addr_i),
        .wb_branch_target_i (wb_branch_target_i),
        .csr_evec_i         (csr_evec_i),
        .pc_o               (pc_o),
        .rf_write_enable_o  (rf_write_enable_o),
        .stage_valid_o      (stage_valid_o),
        .flush_o            (flush_o),
        .stall_o            (stall_o)
    );

    // 100 ns period
    always #50 clk_i = ~clk_i;

    // run limit
    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("run did not finish within %0d cycles, stopped", cycle_cnt);
            $display("Test FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // true about once in den draws, upper bits are the better ones
    function automatic logic one_in(input int unsigned den);
        rand_state = lcg_next(rand_state);
        return (32'(rand_state[31:16]) % den) == 0;
    endfunction

    // word aligned target
    function automatic logic [31:0] random_addr();
        rand_state = lcg_next(rand_state);
        return {rand_state[31:2], 2'b00};
    endfunction

    task automatic set_idle();
        valid_fetch_i      = 1'b0;
        id_valid_jal_i     = 1'b0;
        id_stall_csr_i     = 1'b0;
        rr_stall_csr_i     = 1'b0;
        exe_stall_csr_i    = 1'b0;
        exe_stall_i        = 1'b0;
        wb_valid_i         = 1'b0;
        wb_xcpt_i          = 1'b0;
        wb_branch_taken_i  = 1'b0;
        wb_change_pc_ena_i = 1'b0;
        wb_ecall_taken_i   = 1'b0;
        wb_write_enable_i  = 1'b0;
        csr_eret_i         = 1'b0;
        csr_exception_i    = 1'b0;
        csr_stall_i        = 1'b0;
        id_jump_addr_i     = '0;
        wb_branch_target_i = '0;
        csr_evec_i         = '0;
    endtask

    // traps and eret kept rare so sequential runs still happen
    task automatic drive_random();
        valid_fetch_i      = !one_in(4);
        id_valid_jal_i     = one_in(8);
        id_stall_csr_i     = one_in(16);
        rr_stall_csr_i     = one_in(16);
        exe_stall_csr_i    = one_in(16);
        exe_stall_i        = one_in(10);
        wb_valid_i         = one_in(2);
        wb_xcpt_i          = one_in(32);
        wb_branch_taken_i  = one_in(4);
        wb_change_pc_ena_i = one_in(2);
        wb_ecall_taken_i   = one_in(32);
        wb_write_enable_i  = one_in(2);
        csr_eret_i         = one_in(64);
        csr_exception_i    = one_in(64);
        csr_stall_i        = one_in(16);
        id_jump_addr_i     = random_addr();
        wb_branch_target_i = random_addr();
        csr_evec_i         = random_addr();
    endtask

    task automatic compare(input string name, input logic [31:0] exp_val,
                           input logic [31:0] act_val);
        check_cnt++;
        if (exp_val !== act_val) begin
            error_cnt++;
            $display("ERR %s expected %h actual %h at cycle %0d",
                     name, exp_val, act_val, cycle_cnt);
        end
    endtask

    // inputs still hold the values driven one negedge ago
    task automatic check_cycle();
        logic                  trap;
        logic                  branch;
        logic                  redirect;
        logic                  hold;
        logic                  exp_rf_we;
        logic [31:0]           target;
        logic [NUM_STAGES-1:0] exp_flush;
        logic [NUM_STAGES-1:0] exp_stall;
        logic [NUM_STAGES-1:0] shifted;
        trap     = (wb_valid_i & (wb_xcpt_i | wb_ecall_taken_i)) |
                   csr_eret_i | csr_exception_i;
        branch   = wb_valid_i & wb_branch_taken_i;
        redirect = trap | (branch & wb_change_pc_ena_i) | id_valid_jal_i;
        hold     = !valid_fetch_i | csr_stall_i | exe_stall_i |
                   id_stall_csr_i | rr_stall_csr_i | exe_stall_csr_i;
        // trap vector beats commit target beats jal target
        target   = trap ? csr_evec_i : (branch ? wb_branch_target_i : id_jump_addr_i);

        exp_stall = (csr_stall_i | exe_stall_i) ? FRONT_STAGES : '0;
        if (trap | branch) begin
            exp_flush = FRONT_STAGES;
        end else if (id_valid_jal_i | id_stall_csr_i | rr_stall_csr_i | exe_stall_csr_i) begin
            exp_flush = ONLY_IF;
        end else begin
            exp_flush = '0;
        end
        exp_rf_we = wb_valid_i & !wb_xcpt_i & !csr_exception_i & wb_write_enable_i;

        compare("flush_o", 32'(exp_flush), 32'(flush_o));
        compare("stall_o", 32'(exp_stall), 32'(stall_o));
        compare("rf_write_enable_o", 32'(exp_rf_we), 32'(rf_write_enable_o));

        // effect of the rising edge just passed
        if (redirect) begin
            model_pc = target;
        end else if (!hold) begin
            model_pc = model_pc + INSN_BYTES;
        end
        // older stage takes younger bit, flushed ones leave a bubble
        shifted     = {model_valid[NUM_STAGES-2:0] & ~exp_flush[NUM_STAGES-2:0],
                       valid_fetch_i};
        model_valid = (model_valid & exp_stall) | (shifted & ~exp_stall);

        compare("pc_o", model_pc, pc_o);
        compare("stage_valid_o", 32'(model_valid), 32'(stage_valid_o));
    endtask

    initial begin
        clk_i       = 1'b0;
        rst_i       = 1'b1;
        rand_state  = 32'had39;
        error_cnt   = 0;
        check_cnt   = 0;
        model_pc    = RESET_PC;
        model_valid = '0;
        set_idle();

        repeat (RESET_CYCLES) @(negedge clk_i);
        // reset values with idle inputs
        compare("pc_o", RESET_PC, pc_o);
        compare("stage_valid_o", 32'(0), 32'(stage_valid_o));
        compare("flush_o", 32'(0), 32'(flush_o));
        compare("stall_o", 32'(0), 32'(stall_o));
        rst_i = 1'b0;

        for (int n = 0; n < NUM_CYCLES; n++) begin
            drive_random();
            @(negedge clk_i);
            check_cycle();
        end

        $display("%0d errors in %0d checks", error_cnt, check_cnt);
        if (error_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule : tb_drac_ctrl

`default_nettype wire

/* sim.f */
hdl/riscv_pkg.sv
hdl/drac_pkg.sv
hdl/pipeline_ctrl_if.sv
hdl/control_unit.sv
hdl/pc_gen.sv
hdl/stage_valid_chain.sv
hdl/drac_ctrl_top.sv
tests/tb_drac_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# build and run the pipeline control testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -f sim.f --top-module tb_drac_ctrl -Mdir obj_dir \
    && ./obj_dir/Vtb_drac_ctrl > sim.log 2>&1 \
    || echo "build or simulation returned an error status"
cat sim.log 2>/dev/null
grep -qx "Test OK" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
